/* hdl/axi_write_pkg.sv */
//////////////////////////////////////////////////////////////////////
// AXI write definitions
// Bus widths, burst limits and the AW and W channel payloads shared
// by the write master blocks
//////////////////////////////////////////////////////////////////////

package axi_write_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  // Bits that select a byte inside one beat
  localparam int BYTE_IDX_WIDTH = $clog2(STRB_WIDTH);

  // Burst shape, 256 beats of 4 bytes
  localparam int BURST_BEATS     = 256;
  localparam int BURST_LEN_WIDTH = 8;
  // Also the address step and the alignment unit
  localparam int BURST_BYTES     = BURST_BEATS * STRB_WIDTH;

  // Outstanding burst limit and counter widths
  localparam int MAX_OUTSTANDING   = 4;
  localparam int OUTSTANDING_WIDTH = 3;
  localparam int PENDING_AW_WIDTH  = 8;

  // Write address channel payload
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      addr;
    logic [BURST_LEN_WIDTH-1:0] len;
  } axi_aw_t;

  // Write data channel payload
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } axi_w_t;

endpackage

/* hdl/xfer_cmd_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Transfer command definitions
// Command as given by the host and the burst plan derived from it
//////////////////////////////////////////////////////////////////////

package xfer_cmd_pkg;

  import axi_write_pkg::*;

  // Byte length of one command
  localparam int XFER_SIZE_WIDTH   = 20;
  // Whole beats minus one, then split into bursts
  localparam int TOTAL_BEATS_WIDTH = XFER_SIZE_WIDTH - BYTE_IDX_WIDTH;
  localparam int TXN_CNT_WIDTH     = 10;

  // Command sampled on ctrl_start
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      addr;
    logic [XFER_SIZE_WIDTH-1:0] size_bytes;
  } xfer_cmd_t;

  // Burst plan, held until the next command
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      base_addr;
    logic [TXN_CNT_WIDTH-1:0]   last_txn_index;
    logic [BURST_LEN_WIDTH-1:0] final_len;
    logic [STRB_WIDTH-1:0]      final_strb;
  } xfer_desc_t;

endpackage

/* hdl/updown_counter.sv */
//////////////////////////////////////////////////////////////////////
// Up/down counter
// Loadable counter with separate up and down strobes and a zero flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module updown_counter import axi_write_pkg::*; #(
  parameter int              WIDTH = BURST_LEN_WIDTH,
  parameter logic [WIDTH-1:0] INIT = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Both strobes together leave the count as it is
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      // wraps from zero to all ones
      count <= count - 1'b1;
    end
  end

  // Zero flag straight from the register
  assign is_zero = (count == '0);

endmodule

/* hdl/xfer_cmd_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Command decoder
// Registers a write command and turns it into a burst plan
// with an aligned base address, burst count, final length and strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module xfer_cmd_decoder import axi_write_pkg::*, xfer_cmd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  xfer_cmd_t  ctrl_cmd,
  output logic       start,
  output xfer_desc_t desc
);

  logic                         start_d1;
  logic [TOTAL_BEATS_WIDTH-1:0] total_len_r;
  logic [ADDR_WIDTH-1:0]        base_addr_r;
  logic [BYTE_IDX_WIDTH-1:0]    byte_rem_r;
  logic [BURST_LEN_WIDTH-1:0]   final_len_r;
  logic [STRB_WIDTH-1:0]        final_strb_r;

  // Start strobe, two cycles behind ctrl_start
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Command capture
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats, kept as count minus one
      if (ctrl_cmd.size_bytes[BYTE_IDX_WIDTH-1:0] != '0) begin
        total_len_r <= ctrl_cmd.size_bytes[BYTE_IDX_WIDTH +: TOTAL_BEATS_WIDTH];
      end else begin
        total_len_r <= ctrl_cmd.size_bytes[BYTE_IDX_WIDTH +: TOTAL_BEATS_WIDTH] - 1'b1;
      end
      // Start on a burst boundary
      base_addr_r <= ctrl_cmd.addr & ~ADDR_WIDTH'(BURST_BYTES - 1);
      byte_rem_r  <= ctrl_cmd.size_bytes[BYTE_IDX_WIDTH-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Second stage, settles together with start
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    final_len_r <= total_len_r[BURST_LEN_WIDTH-1:0];
    // No remainder means the last beat is full
    for (int i = 0; i < STRB_WIDTH; i++) begin
      final_strb_r[i] <= (byte_rem_r == '0) || (i < byte_rem_r);
    end
  end

  // Upper bits of the beat count give bursts minus one
  assign desc = '{
    base_addr:      base_addr_r,
    last_txn_index: total_len_r[BURST_LEN_WIDTH +: TXN_CNT_WIDTH],
    final_len:      final_len_r,
    final_strb:     final_strb_r
  };

endmodule

/* hdl/wdata_channel.sv */
//////////////////////////////////////////////////////////////////////
// Write data channel
// Passes the stream onto W, cuts it into bursts with last and strobe,
// and flags the first beat of every burst for the address channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wdata_channel import axi_write_pkg::*, xfer_cmd_pkg::*; (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  xfer_desc_t            desc,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic [DATA_WIDTH-1:0] s_axis_tdata,
  output axi_w_t                m_axi_w,
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  output logic                  burst_open
);

  logic                     running;
  logic                     wxfer;
  logic                     w_last;
  logic                     final_txn;
  logic                     almost_final_txn;
  logic                     single_txn;
  logic                     load_beats;
  logic [TXN_CNT_WIDTH-1:0] txns_to_go;
  logic                     final_xfer;
  // First beat tracking
  logic                     wfirst;
  logic                     announced;
  logic                     first_seen;
  logic                     first_seen_d1;

  ////////////////////////////////////////////////////////////////////
  // Stream gating
  ////////////////////////////////////////////////////////////////////

  // Nothing moves before the plan is known
  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  // No storage, W and the stream handshake together
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign wxfer         = m_axi_wvalid & m_axi_wready;

  ////////////////////////////////////////////////////////////////////
  // Beat and burst accounting
  ////////////////////////////////////////////////////////////////////

  assign single_txn       = (desc.last_txn_index == '0);
  assign almost_final_txn = (txns_to_go == TXN_CNT_WIDTH'(1));
  // Short burst is loaded just before it starts
  assign load_beats = (wxfer & w_last & almost_final_txn) | (start & single_txn);
  assign final_xfer = wxfer & w_last & final_txn;

  // Full bursts come from wrapping past zero
  updown_counter #(
    .WIDTH (BURST_LEN_WIDTH),
    .INIT  ('1)
  ) beat_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (desc.final_len),
    .count      (),
    .is_zero    (w_last)
  );

  // Bursts still to finish, minus one
  updown_counter #(
    .WIDTH (TXN_CNT_WIDTH),
    .INIT  ('0)
  ) burst_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer & w_last),
    .load_value (desc.last_txn_index),
    .count      (txns_to_go),
    .is_zero    (final_txn)
  );

  // Partial strobe only on the very last beat
  assign m_axi_w = '{
    data: s_axis_tdata,
    strb: (w_last & final_txn) ? desc.final_strb : '1,
    last: w_last
  };

  ////////////////////////////////////////////////////////////////////
  // Burst open pulse
  ////////////////////////////////////////////////////////////////////

  // Next beat starts a burst after each last beat
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst <= 1'b1;
    end else if (wxfer) begin
      wfirst <= w_last;
    end
  end

  // Once per burst, even if valid drops before the first beat moves
  assign first_seen = m_axi_wvalid & wfirst & ~announced;

  always_ff @(posedge aclk) begin
    if (areset) begin
      announced <= 1'b0;
    end else if (wxfer & w_last) begin
      announced <= 1'b0;
    end else if (first_seen) begin
      announced <= 1'b1;
    end
  end

  // Two register stages to the address channel
  always_ff @(posedge aclk) begin
    if (areset) begin
      first_seen_d1 <= 1'b0;
      burst_open    <= 1'b0;
    end else begin
      first_seen_d1 <= first_seen;
      burst_open    <= first_seen_d1;
    end
  end

endmodule

/* hdl/waddr_channel.sv */
//////////////////////////////////////////////////////////////////////
// Write address channel
// Offers one burst address per opened burst, stepping through the
// aligned range and holding each request until accepted
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module waddr_channel import axi_write_pkg::*, xfer_cmd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  xfer_desc_t desc,
  input  logic       burst_open,
  input  logic       aw_stall,
  output axi_aw_t    m_axi_aw,
  output logic       m_axi_awvalid,
  input  logic       m_axi_awready,
  output logic       aw_xfer
);

  logic                  awvalid_r;
  logic                  idle_aw;
  logic                  aw_final_txn;
  logic [ADDR_WIDTH-1:0] addr_r;

  assign m_axi_awvalid = awvalid_r;
  assign aw_xfer       = awvalid_r & m_axi_awready;

  // Bursts whose data has shown up but whose address is not out
  updown_counter #(
    .WIDTH (PENDING_AW_WIDTH),
    .INIT  ('0)
  ) pending_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_open),
    .decr       (aw_xfer),
    .load_value ('0),
    .count      (),
    .is_zero    (idle_aw)
  );

  // Offer a new request only when none is out
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!idle_aw && !awvalid_r && !aw_stall) begin
      awvalid_r <= 1'b1;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  // Address moves on acceptance only
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= desc.base_addr;
    end else if (aw_xfer) begin
      addr_r <= addr_r + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  // Zero flag marks the last address of the command
  updown_counter #(
    .WIDTH (TXN_CNT_WIDTH),
    .INIT  ('0)
  ) addr_burst_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (aw_xfer),
    .load_value (desc.last_txn_index),
    .count      (),
    .is_zero    (aw_final_txn)
  );

  assign m_axi_aw = '{
    addr: addr_r,
    len:  aw_final_txn ? desc.final_len : BURST_LEN_WIDTH'(BURST_BEATS - 1)
  };

endmodule

/* hdl/wresp_tracker.sv */
//////////////////////////////////////////////////////////////////////
// Write response tracker
// Counts responses to the end of a command and limits bursts in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wresp_tracker import axi_write_pkg::*, xfer_cmd_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  xfer_desc_t desc,
  input  logic       aw_xfer,
  input  logic       m_axi_bvalid,
  output logic       aw_stall,
  output logic       ctrl_done
);

  logic final_resp;

  // Responses still to come, minus one
  updown_counter #(
    .WIDTH (TXN_CNT_WIDTH),
    .INIT  ('0)
  ) resp_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (m_axi_bvalid),
    .load_value (desc.last_txn_index),
    .count      (),
    .is_zero    (final_resp)
  );

  // Done one cycle after the last response
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= m_axi_bvalid & final_resp;
    end
  end

  // Free slots for bursts in flight
  updown_counter #(
    .WIDTH (OUTSTANDING_WIDTH),
    .INIT  (OUTSTANDING_WIDTH'(MAX_OUTSTANDING))
  ) vacancy_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (m_axi_bvalid),
    .decr       (aw_xfer),
    .load_value ('0),
    .count      (),
    .is_zero    (aw_stall)
  );

endmodule

/* hdl/axi_stream_write_master.sv */
//////////////////////////////////////////////////////////////////////
// AXI4-Stream to AXI4 write master
// Moves a stream of words to memory in bursts of 256 beats
// and pulses done after the final write response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_stream_write_master import axi_write_pkg::*, xfer_cmd_pkg::*; (
  input  logic                  aclk,
  input  logic                  areset,
  // Command
  input  logic                  ctrl_start,
  input  xfer_cmd_t             ctrl_cmd,
  output logic                  ctrl_done,
  // Stream in
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic [DATA_WIDTH-1:0] s_axis_tdata,
  // AXI4 write out
  output axi_aw_t               m_axi_aw,
  output logic                  m_axi_awvalid,
  input  logic                  m_axi_awready,
  output axi_w_t                m_axi_w,
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  input  logic                  m_axi_bvalid
);

  logic       start;
  xfer_desc_t desc;
  logic       burst_open;
  logic       aw_xfer;
  logic       aw_stall;

  xfer_cmd_decoder xfer_cmd_decoder_inst (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_cmd   (ctrl_cmd),
    .start      (start),
    .desc       (desc)
  );

  // Data leads, the address follows its first beat
  wdata_channel wdata_channel_inst (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .desc          (desc),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .burst_open    (burst_open)
  );

  waddr_channel waddr_channel_inst (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .desc          (desc),
    .burst_open    (burst_open),
    .aw_stall      (aw_stall),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .aw_xfer       (aw_xfer)
  );

  wresp_tracker wresp_tracker_inst (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .desc         (desc),
    .aw_xfer      (aw_xfer),
    .m_axi_bvalid (m_axi_bvalid),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

/* dv/write_checker.sv */
//////////////////////////////////////////////////////////////////////
// Write checker
// Watches the write master ports and compares bursts, beats, strobes
// and responses against the trace and the burst rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module write_checker import axi_write_pkg::*, xfer_cmd_pkg::*; #(
  parameter logic [DATA_WIDTH-1:0] WORD_STEP = 32'h0100_0000,
  parameter int                    TRACE_WORDS = 80
) (
  input  logic      aclk,
  input  logic      areset,
  input  logic      ctrl_start,
  input  xfer_cmd_t ctrl_cmd,
  input  logic      ctrl_done,
  input  logic      s_axis_tready,
  input  axi_aw_t   m_axi_aw,
  input  logic      m_axi_awvalid,
  input  logic      m_axi_awready,
  input  axi_w_t    m_axi_w,
  input  logic      m_axi_wvalid,
  input  logic      m_axi_wready,
  input  logic      m_axi_bvalid,
  output int        error_count,
  output int        tests_passed,
  output int        tests_failed
);

  logic [31:0] trace_mem [0:TRACE_WORDS-1];
  int errors = 0;
  int passed = 0;
  int failed = 0;

  // Expected shape of the running command
  int                    cmd_idx = -1;
  int                    cmd_errors;
  logic                  busy = 1'b0;
  logic                  done_seen;
  logic [ADDR_WIDTH-1:0] exp_base;
  logic [STRB_WIDTH-1:0] exp_strb;
  int                    exp_beats;
  int                    exp_bursts;
  int                    exp_final_len;
  logic                  exp_last;

  // Progress, per command and in total
  int      opened;
  int      aw_count;
  int      w_beats;
  int      w_bursts;
  int      beat_in_burst;
  int      resp_count;
  int      aw_total = 0;
  int      resp_total = 0;
  logic    aw_waiting = 1'b0;
  axi_aw_t aw_held;

  assign error_count  = errors;
  assign tests_passed = passed;
  assign tests_failed = failed;

  initial begin
    $readmemh("dv/write_trace.txt", trace_mem);
  end

  task print_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors = errors + 1;
  endtask

  task fail_check(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors = errors + 1;
  endtask

  // Full bursts except the last one
  function int expected_len(input int burst);
    return (burst == exp_bursts - 1) ? exp_final_len : BURST_BEATS - 1;
  endfunction

  task finish_command;
    if (done_seen) begin
      fail_check("done pulsed more than once for one command");
    end else begin
      done_seen = 1'b1;
      if (resp_count != exp_bursts) begin
        fail_check($sformatf("done after %0d of %0d responses", resp_count, exp_bursts));
      end
      if (aw_count != exp_bursts) begin
        print_mismatch($sformatf("%0d bursts, expected %0d", aw_count, exp_bursts));
      end
      if (w_beats != exp_beats) begin
        print_mismatch($sformatf("%0d beats, expected %0d", w_beats, exp_beats));
      end
      if (errors == cmd_errors) begin
        passed = passed + 1;
        $display("Command %0d addr %h size %0d: pass", cmd_idx, exp_base, exp_beats);
      end else begin
        failed = failed + 1;
        $display("Command %0d addr %h size %0d: fail", cmd_idx, exp_base, exp_beats);
      end
    end
  endtask

  always @(posedge aclk) begin
    if (!areset) begin
      if (!busy && s_axis_tready) begin
        fail_check("tready high while no command was active");
      end
      // New command, burst shape from the trace
      if (ctrl_start) begin
        cmd_idx       = cmd_idx + 1;
        cmd_errors    = errors;
        // Whole bursts below the command address
        exp_base      = (ctrl_cmd.addr / ADDR_WIDTH'(BURST_BYTES)) * ADDR_WIDTH'(BURST_BYTES);
        exp_beats     = (int'(ctrl_cmd.size_bytes) + STRB_WIDTH - 1) / STRB_WIDTH;
        exp_bursts    = int'(trace_mem[5 * cmd_idx + 2]);
        exp_final_len = int'(trace_mem[5 * cmd_idx + 3]);
        exp_strb      = STRB_WIDTH'(trace_mem[5 * cmd_idx + 4]);
        opened        = 0;
        aw_count      = 0;
        w_beats       = 0;
        w_bursts      = 0;
        beat_in_burst = 0;
        resp_count    = 0;
        done_seen     = 1'b0;
        busy          = 1'b1;
      end
      // First beat of a burst on offer
      if (m_axi_wvalid && busy && opened == w_bursts) begin
        opened = opened + 1;
      end
      if (aw_waiting) begin
        if (!m_axi_awvalid) begin
          fail_check("awvalid dropped before awready");
        end else if (m_axi_aw !== aw_held) begin
          print_mismatch("address or length changed while waiting for awready");
        end
      end
      aw_waiting = m_axi_awvalid && !m_axi_awready;
      aw_held    = m_axi_aw;

      //////////////////////////////////////////////////////////////////
      // Address channel
      //////////////////////////////////////////////////////////////////
      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_count >= exp_bursts) begin
          fail_check("address accepted beyond the expected burst count");
        end else begin
          if (m_axi_aw.addr !== exp_base + ADDR_WIDTH'(aw_count * BURST_BYTES)) begin
            print_mismatch($sformatf("burst %0d addr %h", aw_count, m_axi_aw.addr));
          end
          if (m_axi_aw.len !== BURST_LEN_WIDTH'(expected_len(aw_count))) begin
            print_mismatch($sformatf("burst %0d len %0d", aw_count, m_axi_aw.len));
          end
        end
        if (aw_count >= opened) begin
          fail_check("address accepted before the first beat of its burst");
        end
        if (aw_total - resp_total >= MAX_OUTSTANDING) begin
          fail_check("too many bursts waiting for a response");
        end
        aw_count = aw_count + 1;
        aw_total = aw_total + 1;
      end

      //////////////////////////////////////////////////////////////////
      // Data channel
      //////////////////////////////////////////////////////////////////
      if (m_axi_wvalid && m_axi_wready) begin
        if (!busy) begin
          fail_check("write beat seen while no command was active");
        end else begin
          exp_last = (beat_in_burst == expected_len(w_bursts));
          if (m_axi_w.data !== DATA_WIDTH'(cmd_idx * WORD_STEP + w_beats)) begin
            print_mismatch($sformatf("beat %0d data %h", w_beats, m_axi_w.data));
          end
          if (m_axi_w.last !== exp_last) begin
            print_mismatch($sformatf("beat %0d last %b", w_beats, m_axi_w.last));
          end
          // Partial strobe only on the final beat
          if (m_axi_w.strb !== ((w_beats == exp_beats - 1) ? exp_strb : '1)) begin
            print_mismatch($sformatf("beat %0d strb %h", w_beats, m_axi_w.strb));
          end
          if (exp_last) begin
            w_bursts      = w_bursts + 1;
            beat_in_burst = 0;
          end else begin
            beat_in_burst = beat_in_burst + 1;
          end
          w_beats = w_beats + 1;
          if (w_beats == exp_beats) begin
            busy = 1'b0;
          end
        end
      end
      if (m_axi_bvalid) begin
        resp_count = resp_count + 1;
        resp_total = resp_total + 1;
      end
      if (ctrl_done) begin
        finish_command();
      end
    end
  end

endmodule

/* dv/axi_stream_write_master_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the AXI4-Stream to AXI4 write master
// Reads commands from a trace, drives the stream and a slave model,
// and hands all comparing to the write checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_stream_write_master_tb import axi_write_pkg::*, xfer_cmd_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MAX_CMDS       = 16;
  // Five words per command line
  localparam int TRACE_WORDS    = 5 * MAX_CMDS;
  // Stream word n of command i is i * WORD_STEP + n
  localparam logic [DATA_WIDTH-1:0] WORD_STEP = 32'h0100_0000;

  logic                  aclk = 1'b0;
  logic                  areset;
  logic                  ctrl_start;
  xfer_cmd_t             ctrl_cmd;
  logic                  ctrl_done;
  logic                  s_axis_tvalid = 1'b0;
  logic                  s_axis_tready;
  logic [DATA_WIDTH-1:0] s_axis_tdata = '0;
  axi_aw_t               m_axi_aw;
  logic                  m_axi_awvalid;
  logic                  m_axi_awready = 1'b0;
  axi_w_t                m_axi_w;
  logic                  m_axi_wvalid;
  logic                  m_axi_wready = 1'b0;
  logic                  m_axi_bvalid = 1'b0;

  logic [31:0] trace_mem [0:TRACE_WORDS-1];
  integer      seed = 85;
  logic        timed_out;
  int          cmd_count;
  int          error_count;
  int          tests_passed;
  int          tests_failed;

  // Stream and slave model state
  logic [31:0] roll;
  int          stream_cmd = -1;
  int          words_sent = 0;
  int          words_total = 0;
  int          cycle = 0;
  int          aw_seen = 0;
  int          resp_sent = 0;
  int          resp_due [$];
  int          due_drop;

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  axi_stream_write_master axi_stream_write_master_inst (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_done     (ctrl_done),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bvalid  (m_axi_bvalid)
  );

  write_checker #(
    .WORD_STEP   (WORD_STEP),
    .TRACE_WORDS (TRACE_WORDS)
  ) write_checker_inst (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_cmd      (ctrl_cmd),
    .ctrl_done     (ctrl_done),
    .s_axis_tready (s_axis_tready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_w       (m_axi_w),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bvalid  (m_axi_bvalid),
    .error_count   (error_count),
    .tests_passed  (tests_passed),
    .tests_failed  (tests_failed)
  );

  //////////////////////////////////////////////////////////////////////
  // Stream source and AXI slave model, one random draw per cycle
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    roll = $random(seed);
    if (areset) begin
      s_axis_tvalid <= 1'b0;
      m_axi_awready <= 1'b0;
      m_axi_wready  <= 1'b0;
      m_axi_bvalid  <= 1'b0;
    end else begin
      // New command restarts the word sequence
      if (ctrl_start) begin
        stream_cmd  = stream_cmd + 1;
        words_sent  = 0;
        words_total = (int'(ctrl_cmd.size_bytes) + STRB_WIDTH - 1) / STRB_WIDTH;
      end
      if (s_axis_tvalid && s_axis_tready) begin
        words_sent = words_sent + 1;
      end
      // A beat on offer stays until taken, W has no storage behind it
      if (!s_axis_tvalid || s_axis_tready) begin
        if (words_sent < words_total) begin
          s_axis_tvalid <= (roll[1:0] != 2'b00);
          s_axis_tdata  <= stream_cmd * WORD_STEP + words_sent;
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
      m_axi_awready <= (roll[3:2] != 2'b00);
      m_axi_wready  <= (roll[5:4] != 2'b00);
      // Responses in order, 3 to 12 cycles after the last beat
      if (m_axi_awvalid && m_axi_awready) begin
        aw_seen = aw_seen + 1;
      end
      if (m_axi_wvalid && m_axi_wready && m_axi_w.last) begin
        resp_due.push_back(cycle + 3 + int'(roll[15:8] % 10));
      end
      m_axi_bvalid <= 1'b0;
      if (resp_due.size() > 0 && resp_sent < aw_seen && cycle >= resp_due[0]) begin
        m_axi_bvalid <= 1'b1;
        due_drop = resp_due.pop_front();
        resp_sent = resp_sent + 1;
      end
    end
    cycle = cycle + 1;
  end

  // Waits for the done pulse of the running command
  task automatic wait_for_done(output logic expired);
    int cycles;
    expired = 1'b1;
    for (cycles = 0; cycles < TIMEOUT_CYCLES; cycles++) begin
      @(posedge aclk);
      if (ctrl_done) begin
        expired = 1'b0;
        break;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Command sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    areset     = 1'b1;
    ctrl_start = 1'b0;
    ctrl_cmd   = '0;
    timed_out  = 1'b0;
    cmd_count  = 0;
    $readmemh("dv/write_trace.txt", trace_mem);
    repeat (RESET_CYCLES) @(posedge aclk);
    areset <= 1'b0;
    repeat (2) @(posedge aclk);
    // A line of zeros ends the trace
    while (!timed_out && cmd_count < MAX_CMDS && trace_mem[5 * cmd_count + 1] != '0) begin
      ctrl_cmd.addr       <= trace_mem[5 * cmd_count];
      ctrl_cmd.size_bytes <= XFER_SIZE_WIDTH'(trace_mem[5 * cmd_count + 1]);
      ctrl_start          <= 1'b1;
      @(posedge aclk);
      ctrl_start <= 1'b0;
      wait_for_done(timed_out);
      if (timed_out) begin
        $display("Timeout: command %0d did not finish within %0d cycles",
                 cmd_count, TIMEOUT_CYCLES);
      end else begin
        cmd_count = cmd_count + 1;
      end
      repeat (3) @(posedge aclk);
    end
    $display("Summary: %0d commands passed, %0d failed, %0d errors",
             tests_passed, tests_failed, error_count);
    if (!timed_out && cmd_count > 0 && error_count == 0 && tests_failed == 0 &&
        tests_passed == cmd_count) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* dv/write_trace.txt */
// Columns: address, size in bytes, expected bursts, final burst length, final strobe
// All values hex, one command per line, a line of zeros ends the list
00001000 00000010 1 03 f
00002345 0000000d 1 03 1
00010000 00000400 1 ff f
000107ff 00000401 2 00 1
00040010 00000a06 3 81 3
00100000 00001800 6 ff f
0008fffc 00000003 1 00 7
00200200 00001403 6 00 7
00003000 00000004 1 00 f
0003fc00 00000ffe 4 ff 3
00000000 00000000 0 00 0

/* axi_stream_write_master.f */
hdl/axi_write_pkg.sv
hdl/xfer_cmd_pkg.sv
hdl/updown_counter.sv
hdl/xfer_cmd_decoder.sv
hdl/wdata_channel.sv
hdl/waddr_channel.sv
hdl/wresp_tracker.sv
hdl/axi_stream_write_master.sv
dv/write_checker.sv
dv/axi_stream_write_master_tb.sv

/* Bender.yml */
package:
  name: axi_stream_write_master

sources:
  # Design
  - files:
      - hdl/axi_write_pkg.sv
      - hdl/xfer_cmd_pkg.sv
      - hdl/updown_counter.sv
      - hdl/xfer_cmd_decoder.sv
      - hdl/wdata_channel.sv
      - hdl/waddr_channel.sv
      - hdl/wresp_tracker.sv
      - hdl/axi_stream_write_master.sv
  # Testbench
  - target: test
    files:
      - dv/write_checker.sv
      - dv/axi_stream_write_master_tb.sv
